// ==== Makefile ====
SIM    = verilator
VFLAGS = --binary --timing --assert -Mdir obj_dir
TOP    = pfb_tb
FLIST  = pfb_small.f
LOG    = sim.log
FAIL   = === FAIL ===
PASS   = === PASS ===

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS)" $(LOG) || (echo "simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/pfb_bus_ctrl.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Memory bus controller: request, grant and rvalid sequencing with
// one outstanding access and discard of responses after a branch
//////////////////////////////////////////////////////////////////////

module pfb_bus_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  // Fetch requests from the aligner
  input  logic           fetch_req_i,    // One-cycle strobe asking for a word
  input  logic           flush_i,        // Branch, drop whatever is still owed
  input  pfb_pkg::addr_t fetch_addr_i,
  // Returned words
  output logic           word_valid_o,   // Pulse per response that was kept
  output pfb_pkg::word_t word_rdata_o,
  output logic           bus_busy_o,
  // Instruction memory
  output logic           instr_req_o,
  output pfb_pkg::addr_t instr_addr_o,
  input  logic           instr_gnt_i,
  input  pfb_pkg::word_t instr_rdata_i,
  input  logic           instr_rvalid_i
);
  import pfb_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        addr_q;   // Word address held while waiting for the grant
  addr_t        addr_d;
  logic         drop_q;   // A branch came in before the grant
  logic         drop_d;
  logic         start;    // Put a new request on the bus this cycle

  // The data path is straight through, only the strobe is qualified
  assign word_rdata_o = instr_rdata_i;

  assign bus_busy_o = (state_q != IDLE) || instr_req_o;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    addr_d       = addr_q;
    drop_d       = drop_q;
    instr_req_o  = 1'b0;
    instr_addr_o = addr_q;
    word_valid_o = 1'b0;
    start        = 1'b0;

    unique case (state_q)
      IDLE: begin
        start = fetch_req_i; // Free bus, accept the aligner right away
      end

      WAIT_GNT: begin
        instr_req_o = 1'b1; // Keep asking with the latched address
        if (flush_i) begin
          drop_d = 1'b1; // Request must still finish, remember to swallow it
        end
        if (instr_gnt_i) begin
          drop_d  = 1'b0;
          state_d = (drop_q || flush_i) ? WAIT_ABORTED : WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          word_valid_o = !flush_i; // Same-cycle branch kills the word
          state_d      = IDLE;
          start        = fetch_req_i; // Back-to-back fetch on the response cycle
        end else if (flush_i) begin
          state_d = WAIT_ABORTED;
        end
      end

      WAIT_ABORTED: begin
        // Response belongs to the old stream and is simply ignored
        if (instr_rvalid_i) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase

    // Launch a new access, memory only sees whole words
    if (start) begin
      instr_req_o  = 1'b1;
      instr_addr_o = {fetch_addr_i[31:2], 2'b00};
      addr_d       = {fetch_addr_i[31:2], 2'b00};
      state_d      = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= RESET_ADDR;
      drop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      drop_q  <= drop_d;
    end
  end

endmodule

// ==== logic/pfb_halfword_store.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Halfword store: cached upper halfword of the last word and the copy
// of a word held back by the decoder
//////////////////////////////////////////////////////////////////////

module pfb_halfword_store (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           word_valid_i,     // Fresh word from the bus controller
  input  logic           keep_upper_i,     // Cache the upper half of the current word
  input  logic           stall_word_i,     // Current word not used up, keep a copy
  input  logic           flush_i,          // Branch drops both buffers
  input  pfb_pkg::word_t word_rdata_i,
  output pfb_pkg::word_t cur_word_o,
  output logic           cur_word_valid_o,
  output pfb_pkg::half_t upper_half_o,
  output logic           upper_valid_o
);
  import pfb_pkg::*;

  word_t stall_word_q;   // Copy of a word the decoder did not take yet
  logic  stalled_q;
  half_t upper_q;        // Upper parcel of the most recent word
  logic  upper_valid_q;

  // The held copy wins, a new word cannot arrive while one is held
  assign cur_word_o       = stalled_q ? stall_word_q : word_rdata_i;
  assign cur_word_valid_o = stalled_q || word_valid_i;

  assign upper_half_o  = upper_q;
  assign upper_valid_o = upper_valid_q;

  // Flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stalled_q     <= 1'b0;
      upper_valid_q <= 1'b0;
    end else if (flush_i) begin
      stalled_q     <= 1'b0; // Old stream is gone
      upper_valid_q <= 1'b0;
    end else begin
      stalled_q <= stall_word_i;
      if (keep_upper_i) begin
        upper_valid_q <= 1'b1; // Stays valid, the aligner knows when it applies
      end
    end
  end

  // Data, qualified by the flags above
  always_ff @(posedge clk) begin
    if (stall_word_i) begin
      stall_word_q <= cur_word_o;
    end
    if (keep_upper_i) begin
      upper_q <= cur_word_o[31:16];
    end
  end

endmodule

// ==== logic/pfb_instr_align.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Instruction aligner: program counter, format decision, output
// assembly and scheduling of word fetches and flushes
//////////////////////////////////////////////////////////////////////

module pfb_instr_align (
  input  logic           clk,
  input  logic           rst_n,
  // Decoder controls
  input  logic           req_i,
  input  logic           branch_i,
  input  logic           ready_i,
  input  pfb_pkg::addr_t addr_i,
  // Word and cached halfword from the store
  input  pfb_pkg::word_t cur_word_i,
  input  logic           cur_word_valid_i,
  input  pfb_pkg::half_t upper_half_i,
  input  logic           upper_valid_i,
  input  logic           bus_busy_i,
  // Control of the bus controller and the store
  output logic           fetch_req_o,
  output pfb_pkg::addr_t fetch_addr_o,
  output logic           flush_o,
  output logic           keep_upper_o,
  output logic           stall_word_o,
  // Decoder results
  output logic           valid_o,
  output pfb_pkg::word_t rdata_o,
  output pfb_pkg::addr_t addr_o,
  output logic           busy_o
);
  import pfb_pkg::*;

  addr_t      pc_q;         // Address of the next instruction to hand out
  addr_t      pc_next;
  addr_t      fetch_base;
  logic       second_q;     // First half of a split instruction is cached
  instr_fmt_e fmt;
  logic       instr_ok;     // A whole instruction is available
  logic       split_need;   // Upper parcel starts a 32-bit instruction
  logic       split_first;
  logic       accept;
  logic       miss;
  logic       prefetch;
  logic       lo_full;
  logic       hi_full;
  logic       reg_full;

  // A parcel is compressed unless both low bits are set
  assign lo_full  = (cur_word_i[1:0] == C_OPCODE_FULL);
  assign hi_full  = (cur_word_i[17:16] == C_OPCODE_FULL);
  assign reg_full = (upper_half_i[1:0] == C_OPCODE_FULL);

  //////////////////////////////////////////////////////////////////////
  // Format decision
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fmt        = C_IN_REG;
    instr_ok   = 1'b0;
    split_need = 1'b0;
    if (second_q) begin
      fmt      = SPLIT_IN_REG;     // Waiting for the lower parcel of the next word
      instr_ok = cur_word_valid_i;
    end else if (pc_q[1]) begin
      if (upper_valid_i) begin
        // Misaligned pc always matches the cached parcel
        if (!reg_full) begin
          instr_ok = 1'b1; // Served without touching memory
        end else begin
          split_need = 1'b1;
        end
      end else if (cur_word_valid_i) begin
        if (!hi_full) begin
          fmt      = C_MISALIGNED;
          instr_ok = 1'b1;
        end else begin
          split_need = 1'b1;
        end
      end
    end else if (cur_word_valid_i) begin
      fmt      = lo_full ? FULL_ALIGNED : C_ALIGNED;
      instr_ok = 1'b1;
    end
  end

  assign valid_o     = req_i && !branch_i && instr_ok;
  assign accept      = valid_o && ready_i;
  assign split_first = split_need && req_i && !branch_i; // Nothing is output, so no stall

  // One adder serves both steps and from a misaligned pc either lands in the next word
  assign pc_next = pc_q + (((fmt == FULL_ALIGNED) || (fmt == SPLIT_IN_REG)) ?
                           WORD_BYTES : HALF_BYTES);

  //////////////////////////////////////////////////////////////////////
  // Output assembly
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (fmt)
      FULL_ALIGNED: rdata_o = cur_word_i;
      C_ALIGNED:    rdata_o = {16'h0000, cur_word_i[15:0]};
      C_MISALIGNED: rdata_o = {16'h0000, cur_word_i[31:16]};
      C_IN_REG:     rdata_o = {16'h0000, upper_half_i};
      SPLIT_IN_REG: rdata_o = {cur_word_i[15:0], upper_half_i}; // Second word over cached half
      default:      rdata_o = cur_word_i;
    endcase
  end

  assign addr_o = pc_q; // Held through the second fetch of a split

  //////////////////////////////////////////////////////////////////////
  // Fetch scheduling
  //////////////////////////////////////////////////////////////////////

  // Next instruction lives in a word not yet fetched
  assign prefetch = accept &&
                    ((fmt == FULL_ALIGNED) || (fmt == C_MISALIGNED) || (fmt == C_IN_REG));
  // Nothing usable at the pc and only an idle bus controller takes the request
  assign miss = req_i && !branch_i && !instr_ok && !split_need && !second_q;

  assign fetch_req_o  = miss || split_first || prefetch;
  assign fetch_base   = miss ? pc_q : pc_next;
  assign fetch_addr_o = {fetch_base[31:2], 2'b00};
  assign flush_o      = branch_i;

  // Cache the upper parcel whenever the next pc will point into it
  assign keep_upper_o = (split_first && !upper_valid_i) ||
                        (accept && ((fmt == C_ALIGNED) || (fmt == SPLIT_IN_REG)));
  assign stall_word_o = cur_word_valid_i && !accept && !split_first && !branch_i;

  assign busy_o = bus_busy_i || second_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q     <= RESET_ADDR;
      second_q <= 1'b0;
    end else if (branch_i) begin
      pc_q     <= addr_i; // Redirect drops any pending half
      second_q <= 1'b0;
    end else begin
      if (accept) begin
        pc_q <= pc_next;
      end
      if (split_first) begin
        second_q <= 1'b1;
      end else if (accept) begin
        second_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/pfb_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, vector types, state and format encodings and
// constants of the small instruction prefetch buffer
//////////////////////////////////////////////////////////////////////

package pfb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32; // Byte address width
  localparam int unsigned WORD_W = 32; // Memory word and full instruction
  localparam int unsigned HALF_W = 16; // One instruction parcel

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [HALF_W-1:0] half_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Memory side handshake of the bus controller
  typedef enum logic [1:0] {
    IDLE,         // Nothing owed by memory
    WAIT_GNT,     // Request held until the grant
    WAIT_RVALID,  // Granted and the response is still owed
    WAIT_ABORTED  // Response owed but no longer wanted after a branch
  } fetch_state_e;

  // Where the instruction at the program counter comes from
  //                 upper  lower
  //   FULL_ALIGNED  [word ][word ]
  //   C_ALIGNED     [ 0   ][word lo]
  //   C_MISALIGNED  [ 0   ][word hi]
  //   C_IN_REG      [ 0   ][cached]
  //   SPLIT_IN_REG  [word lo][cached]
  typedef enum logic [2:0] {
    FULL_ALIGNED,
    C_ALIGNED,
    C_MISALIGNED,
    C_IN_REG,
    SPLIT_IN_REG
  } instr_fmt_e;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam addr_t      WORD_BYTES    = addr_t'(4); // Step past a 32-bit instruction
  localparam addr_t      HALF_BYTES    = addr_t'(2); // Step past a compressed one
  localparam logic [1:0] C_OPCODE_FULL = 2'b11;      // Low bits of a 32-bit instruction
  localparam addr_t      RESET_ADDR    = '0;         // First fetch after reset

endpackage

// ==== logic/pfb_prefetch_top.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Top of the small prefetch buffer: bus controller and halfword
// store side by side, joined by the instruction aligner
//////////////////////////////////////////////////////////////////////

module pfb_prefetch_top (
  input  logic           clk,
  input  logic           rst_n,
  // Decoder interface
  input  logic           req_i,
  input  logic           branch_i,
  input  pfb_pkg::addr_t addr_i,
  input  logic           ready_i,
  output logic           valid_o,
  output pfb_pkg::word_t rdata_o,
  output pfb_pkg::addr_t addr_o,
  output logic           busy_o,
  // Instruction memory
  output logic           instr_req_o,
  input  logic           instr_gnt_i,
  output pfb_pkg::addr_t instr_addr_o,
  input  pfb_pkg::word_t instr_rdata_i,
  input  logic           instr_rvalid_i
);
  import pfb_pkg::*;

  logic  fetch_req;
  addr_t fetch_addr;
  logic  flush;
  logic  word_valid;
  word_t word_rdata;
  logic  bus_busy;
  logic  keep_upper;
  logic  stall_word;
  word_t cur_word;
  logic  cur_word_valid;
  half_t upper_half;
  logic  upper_valid;

  pfb_bus_ctrl u_bus (
    .clk, .rst_n,
    .fetch_req_i (fetch_req), .flush_i (flush), .fetch_addr_i (fetch_addr),
    .word_valid_o (word_valid), .word_rdata_o (word_rdata), .bus_busy_o (bus_busy),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rdata_i, .instr_rvalid_i
  );

  pfb_halfword_store u_store (
    .clk, .rst_n,
    .word_valid_i (word_valid), .keep_upper_i (keep_upper), .stall_word_i (stall_word),
    .flush_i (flush), .word_rdata_i (word_rdata),
    .cur_word_o (cur_word), .cur_word_valid_o (cur_word_valid),
    .upper_half_o (upper_half), .upper_valid_o (upper_valid)
  );

  pfb_instr_align u_align (
    .clk, .rst_n, .req_i, .branch_i, .ready_i, .addr_i,
    .cur_word_i (cur_word), .cur_word_valid_i (cur_word_valid),
    .upper_half_i (upper_half), .upper_valid_i (upper_valid), .bus_busy_i (bus_busy),
    .fetch_req_o (fetch_req), .fetch_addr_o (fetch_addr), .flush_o (flush),
    .keep_upper_o (keep_upper), .stall_word_o (stall_word),
    .valid_o, .rdata_o, .addr_o, .busy_o
  );

endmodule

// ==== pfb_small.f ====
logic/pfb_pkg.sv
logic/pfb_bus_ctrl.sv
logic/pfb_halfword_store.sv
logic/pfb_instr_align.sv
logic/pfb_prefetch_top.sv
testbench/pfb_checker.sv
testbench/pfb_tb.sv

// ==== testbench/pfb_checker.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the memory handshake, the output hold under
// back-pressure and the outputs right after reset
//////////////////////////////////////////////////////////////////////

module pfb_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           req_i,
  input logic           branch_i,
  input logic           ready_i,
  input logic           valid_o,
  input pfb_pkg::word_t rdata_o,
  input pfb_pkg::addr_t addr_o,
  input logic           busy_o,
  input logic           instr_req_o,
  input logic           instr_gnt_i,
  input pfb_pkg::addr_t instr_addr_o
);

  // Request and its address stay put until memory grants
  req_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_req_o dropped or instr_addr_o moved before the grant");

  // A held instruction only goes away on a branch or a dropped request
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=>
      !req_i || branch_i || (valid_o && $stable(rdata_o) && $stable(addr_o)))
    else $error("rdata_o or addr_o changed while the decoder held it off");

  idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !valid_o && !instr_req_o && !busy_o)
    else $error("valid_o, instr_req_o or busy_o high right after reset");

endmodule

bind pfb_prefetch_top pfb_checker checker_i (
  .clk, .rst_n, .req_i, .branch_i, .ready_i, .valid_o, .rdata_o, .addr_o,
  .busy_o, .instr_req_o, .instr_gnt_i, .instr_addr_o
);

// ==== testbench/pfb_tb.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench of the prefetch buffer: clock, reset, instruction memory
// model, reference instruction stream and the directed tests
//////////////////////////////////////////////////////////////////////

module pfb_tb;
  import pfb_pkg::*;

  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned TOTAL_INSTR = 44;                         // Sum over all streams
  localparam int unsigned WATCHDOG_NS = (TOTAL_INSTR * 8 + 400) * 8;

  logic  clk;
  logic  rst_n;
  logic  req_i;
  logic  branch_i;
  logic  ready_i;
  addr_t addr_i;
  logic  valid_o;
  word_t rdata_o;
  addr_t addr_o;
  logic  busy_o;
  logic  instr_req_o;
  addr_t instr_addr_o;
  logic  instr_gnt_i    = 1'b0; // Memory side inputs belong to the model below
  logic  instr_rvalid_i = 1'b0;
  word_t instr_rdata_i  = '0;

  word_t       mem [MEM_WORDS];
  logic        owed;            // Granted access still waiting for its rvalid
  addr_t       owed_addr;
  int unsigned rv_wait;
  int unsigned gnt_wait;
  logic        slow_rvalid;     // Forces the longest response delay
  word_t       exp_data [$];
  addr_t       exp_addr [$];
  int unsigned checks;
  int unsigned errors;
  int unsigned test_errors;

  pfb_prefetch_top dut_i (
    .clk, .rst_n, .req_i, .branch_i, .addr_i, .ready_i, .valid_o, .rdata_o, .addr_o,
    .busy_o, .instr_req_o, .instr_gnt_i, .instr_addr_o, .instr_rdata_i, .instr_rvalid_i
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      owed     = 1'b0;
      rv_wait  = 0;
      gnt_wait = 0;
    end else begin
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        owed      = 1'b1;
        owed_addr = instr_addr_o;
        rv_wait   = slow_rvalid ? 2 : $urandom_range(2, 0); // rvalid 1 to 3 cycles on
        gnt_wait  = $urandom_range(2, 0);
      end else if (gnt_wait != 0) begin
        gnt_wait--;
      end
      instr_gnt_i <= (gnt_wait == 0);
      if (owed) begin
        if (rv_wait == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= mem[owed_addr[9:2]];
          owed = 1'b0;
        end else begin
          rv_wait--;
        end
      end
    end
  end

  function automatic half_t half_at(addr_t a);
    word_t w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Random parcel that is either a full opcode start or a compressed one
  function automatic half_t rand_parcel(bit full);
    half_t h;
    h = half_t'($urandom);
    if (full) begin
      h[1:0] = 2'b11;
    end else if (h[1:0] == 2'b11) begin
      h[1:0] = 2'b10;
    end
    return h;
  endfunction

  task automatic load_image();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $urandom; // Background, the random stream runs at 0x300
    end
    for (int i = 0; i < 8; i++) begin
      mem[i] = {half_t'($urandom), rand_parcel(1'b1)};     // Aligned 32-bit only
      mem[64 + i] = {rand_parcel(1'b0), rand_parcel(1'b0)}; // Compressed only at 0x100
    end
    mem[128] = {rand_parcel(1'b1), rand_parcel(1'b0)}; // 0x202 starts a split
    mem[129] = {rand_parcel(1'b1), rand_parcel(1'b0)}; // 0x206 starts another
    mem[130] = {rand_parcel(1'b0), rand_parcel(1'b0)};
    mem[131] = {half_t'($urandom), rand_parcel(1'b1)};
    mem[132] = {rand_parcel(1'b0), rand_parcel(1'b0)};
  endtask

  // Walk the image by the length rule of the low two bits
  task automatic build_expected(addr_t start, int unsigned count);
    addr_t a;
    half_t h;
    a = start;
    exp_data.delete();
    exp_addr.delete();
    repeat (count) begin
      h = half_at(a);
      exp_addr.push_back(a);
      if (h[1:0] != 2'b11) begin
        exp_data.push_back({16'h0000, h});
        a = a + 2;
      end else begin
        exp_data.push_back({half_at(a + 2), h});
        a = a + 4;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string sig, word_t exp, word_t got);
    checks++;
    assert (got == exp) else begin
      $display("FAIL %s expected %h got %h at %0t", sig, exp, got, $time);
      test_errors++;
    end
  endtask

  task automatic report_test(string name);
    $display("%s: %0d errors", name, test_errors);
    errors += test_errors;
    test_errors = 0;
  endtask

  task automatic redirect(addr_t target);
    branch_i <= 1'b1;
    addr_i   <= target;
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  // Collect count instructions and compare each against the reference
  task automatic run_stream(string name, addr_t start, int unsigned count, bit rand_ready);
    int unsigned got;
    bit          held;
    word_t       held_data;
    addr_t       held_addr;
    build_expected(start, count);
    got  = 0;
    held = 1'b0;
    req_i   <= 1'b1;
    ready_i <= rand_ready ? ($urandom_range(2, 0) != 0) : 1'b1;
    while (got < count) begin
      @(posedge clk);
      if (held) begin
        checks++;
        assert (valid_o && rdata_o == held_data && addr_o == held_addr) else begin
          $display("held instruction changed while ready_i was low at %0t", $time);
          test_errors++;
        end
      end
      held      = valid_o && !ready_i;
      held_data = rdata_o;
      held_addr = addr_o;
      if (valid_o && ready_i) begin
        check_value("rdata_o", exp_data[got], rdata_o);
        check_value("addr_o", exp_addr[got], addr_o);
        got++;
        if (got == count) begin
          req_i <= 1'b0; // Stop before another fetch is scheduled
        end
      end
      if (rand_ready) begin
        ready_i <= ($urandom_range(2, 0) != 0);
      end
    end
    ready_i <= 1'b1;
    report_test(name);
  endtask

  // Branch away right after a grant while the rvalid is held back
  task automatic abort_in_flight();
    bit          granted;
    int unsigned waited;
    slow_rvalid = 1'b1;
    redirect(32'h0000_0100);
    req_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      granted = instr_req_o && instr_gnt_i;
      waited++;
    end while (!granted && waited < 20);
    assert (granted) else begin
      $display("no grant came for the fetch at 0x100");
      test_errors++;
    end
    redirect(32'h0000_0206);
    slow_rvalid = 1'b0;
    run_stream("abort", 32'h0000_0206, 5, 1'b0);
  endtask

  task automatic drain_check();
    int unsigned cycles;
    req_i <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while ((busy_o || instr_req_o) && cycles < 40);
    checks++;
    assert (!busy_o && !instr_req_o) else begin
      $display("busy_o or instr_req_o still high %0d cycles after the stream ended", cycles);
      test_errors++;
    end
    report_test("drain");
  endtask

  initial begin
    void'($urandom(32'hc450));
    rst_n       = 1'b0;
    req_i       = 1'b0;
    branch_i    = 1'b0;
    ready_i     = 1'b1;
    addr_i      = '0;
    slow_rvalid = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    load_image();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run_stream("aligned", 32'h0000_0000, 8, 1'b0); // Straight from the reset address
    redirect(32'h0000_0100);
    run_stream("compressed", 32'h0000_0100, 12, 1'b0);
    redirect(32'h0000_0200);
    run_stream("split", 32'h0000_0200, 7, 1'b0);
    abort_in_flight();
    redirect(32'h0000_0300);
    run_stream("backpressure", 32'h0000_0300, 12, 1'b1);
    drain_check();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Worst case of 8 cycles per instruction plus room for setup and drain
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT stopped delivering", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
